/* common/cb_route_pkg.sv */
package cb_route_pkg;

  // ################################################
  // Row geometry
  // ################################################

  // Lanes per covariance buffer row
  localparam int CB_LANES = 4;

  // Operand widths on the array side, in words
  localparam int CB_X = 4;
  localparam int CB_Y = 4;

  // ################################################
  // Command opcodes
  // ################################################

  // Where a mapped row is sent
  typedef enum logic [1:0] {
    DEST_TB = 2'b00,
    DEST_A  = 2'b01,
    DEST_B  = 2'b10,
    DEST_M  = 2'b11
  } cb_dest_e;

  // How the lanes of a row are reordered
  typedef enum logic [1:0] {
    DIR_IDLE = 2'b00,
    DIR_POS  = 2'b01,
    DIR_NEG  = 2'b10,
    DIR_NEW  = 2'b11
  } cb_dir_e;

  // Lane of the NEW pair. Odd landmarks sit in lanes 0 and 1, even ones in lanes 2 and 3
  function automatic int unsigned new_pair_lane(input logic l_k_0, input logic upper);
    return (l_k_0 ? 0 : 2) + (upper ? 1 : 0);
  endfunction

endpackage

/* common/cb_seq_pkg.sv */
package cb_seq_pkg;

  // ################################################
  // Sequencer definitions
  // ################################################

  // Width of the beat index and of the command length
  localparam int SEQ_CNT_DW = 10;

  // ST_RUN issues one row per cycle.
  // ST_DRAIN waits for the rows still inside the bank and mapper
  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_RUN   = 2'b01,
    ST_DRAIN = 2'b10
  } cb_seq_state_e;

endpackage

/* common/cb_rd_if.sv */
`timescale 1ns/1ps

interface cb_rd_if #(
  parameter int CB_AW = 6
);

  // Read request and its route
  logic                              rd_en;
  logic [CB_AW-1:0]                  rd_addr;
  cb_route_pkg::cb_dest_e            dest;
  cb_route_pkg::cb_dir_e             dir;
  logic                              l_k_0;
  logic [cb_seq_pkg::SEQ_CNT_DW-1:0] step;

  // Marks a slot that carries read data out of the bank
  logic                              valid;

  modport issue (output rd_en, output rd_addr, output dest, output dir,
                 output l_k_0, output step);

  modport bank (input rd_en, input rd_addr, input dest, input dir,
                input l_k_0, input step);

  // The bank fills this slot beside its read data and the mapper consumes it
  modport map (output valid, output dest, output dir, output l_k_0, output step);

endinterface

/* src/cb_step_counter.sv */
`timescale 1ns/1ps

module cb_step_counter #(
  parameter int CB_AW = 6
) (
  input  logic                              clk,
  input  logic                              sys_rst,
  input  logic                              i_load,
  input  logic                              i_en,
  input  logic [CB_AW-1:0]                  i_base,
  input  logic [cb_seq_pkg::SEQ_CNT_DW-1:0] i_len,
  output logic [CB_AW-1:0]                  o_addr,
  output logic [cb_seq_pkg::SEQ_CNT_DW-1:0] o_step,
  output logic                              o_last
);

  logic [cb_seq_pkg::SEQ_CNT_DW-1:0] last_step;

  // A zero length still reads one row
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_addr    <= '0;
      o_step    <= '0;
      last_step <= '0;
    end else if (i_load) begin
      o_addr    <= i_base;
      o_step    <= '0;
      last_step <= (i_len == '0) ? '0 : i_len - 1'b1;
    end else if (i_en) begin
      // The address rolls over at the top row of the buffer
      o_addr    <= o_addr + 1'b1;
      o_step    <= o_step + 1'b1;
    end
  end

  assign o_last = (o_step == last_step);

endmodule

/* src/cb_seq_fsm.sv */
`timescale 1ns/1ps

module cb_seq_fsm #(
  parameter int CB_AW = 6
) (
  input  logic                              clk,
  input  logic                              sys_rst,
  input  logic                              i_cmd_valid,
  input  cb_route_pkg::cb_dest_e            i_cmd_dest,
  input  cb_route_pkg::cb_dir_e             i_cmd_dir,
  input  logic [1:0]                        i_cmd_lm_idx,
  input  logic [CB_AW-1:0]                  i_cnt_addr,
  input  logic [cb_seq_pkg::SEQ_CNT_DW-1:0] i_cnt_step,
  input  logic                              i_cnt_last,
  output logic                              o_cmd_ready,
  output logic                              o_cnt_load,
  output logic                              o_cnt_en,
  output logic                              o_done,
  cb_rd_if.issue                            o_rd
);

  cb_seq_pkg::cb_seq_state_e state;
  cb_seq_pkg::cb_seq_state_e state_nxt;
  logic                      accept;
  logic                      issue_last;
  logic [1:0]                done_dly;

  assign o_cmd_ready = (state == cb_seq_pkg::ST_IDLE);
  assign accept      = i_cmd_valid & o_cmd_ready;
  assign o_cnt_load  = accept;
  assign o_cnt_en    = (state == cb_seq_pkg::ST_RUN);

  // ################################################
  // State machine
  // ################################################

  always_comb begin
    state_nxt = state;
    case (state)
      cb_seq_pkg::ST_IDLE: begin
        if (accept) state_nxt = cb_seq_pkg::ST_RUN;
      end
      cb_seq_pkg::ST_RUN: begin
        if (i_cnt_last) state_nxt = cb_seq_pkg::ST_DRAIN;
      end
      cb_seq_pkg::ST_DRAIN: begin
        // Leave once the last beat is on the outputs
        if (done_dly[1]) state_nxt = cb_seq_pkg::ST_IDLE;
      end
      default: state_nxt = cb_seq_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state <= cb_seq_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ################################################
  // Read issue
  // ################################################

  // Route fields are held for the whole burst
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_rd.dest  <= cb_route_pkg::DEST_TB;
      o_rd.dir   <= cb_route_pkg::DIR_IDLE;
      o_rd.l_k_0 <= 1'b0;
    end else if (accept) begin
      o_rd.dest  <= i_cmd_dest;
      o_rd.dir   <= i_cmd_dir;
      o_rd.l_k_0 <= i_cmd_lm_idx[0];
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_rd.rd_en <= 1'b0;
      issue_last <= 1'b0;
      done_dly   <= 2'b00;
    end else begin
      o_rd.rd_en <= o_cnt_en;
      issue_last <= o_cnt_en & i_cnt_last;
      // Bank and mapper each add one stage behind the issued read
      done_dly   <= {done_dly[0], issue_last};
    end
  end

  always_ff @(posedge clk) begin
    o_rd.rd_addr <= i_cnt_addr;
    o_rd.step    <= i_cnt_step;
  end

  assign o_done = done_dly[1];

endmodule

/* cb_bank/cb_bank.sv */
`timescale 1ns/1ps

module cb_bank #(
  parameter int RSA_DW = 32,
  parameter int CB_AW  = 6
) (
  input  logic                                            clk,
  input  logic                                            sys_rst,
  input  logic                                            i_wr_en,
  input  logic [CB_AW-1:0]                                i_wr_addr,
  input  logic [cb_route_pkg::CB_LANES*RSA_DW-1:0]        i_wr_data,
  cb_rd_if.bank                                           i_rd,
  cb_rd_if.map                                            o_slot,
  output logic signed [cb_route_pkg::CB_LANES*RSA_DW-1:0] o_douta
);

  localparam int ROW_W = cb_route_pkg::CB_LANES * RSA_DW;
  localparam int DEPTH = 2 ** CB_AW;

  logic [ROW_W-1:0] mem [DEPTH];

  // ################################################
  // Row storage
  // ################################################

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // A read of the row being written returns its previous contents
  always_ff @(posedge clk) begin
    if (i_rd.rd_en) begin
      o_douta <= mem[i_rd.rd_addr];
    end
  end

  // ################################################
  // Slot copy
  // ################################################

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_slot.valid <= 1'b0;
    end else begin
      o_slot.valid <= i_rd.rd_en;
    end
  end

  // Each row leaves with the route it was read for
  always_ff @(posedge clk) begin
    if (i_rd.rd_en) begin
      o_slot.dest  <= i_rd.dest;
      o_slot.dir   <= i_rd.dir;
      o_slot.l_k_0 <= i_rd.l_k_0;
      o_slot.step  <= i_rd.step;
    end
  end

endmodule

/* cb_map/cb_douta_map.sv */
`timescale 1ns/1ps

module cb_douta_map #(
  parameter int RSA_DW = 32
) (
  input  logic                                            clk,
  input  logic                                            sys_rst,
  input  logic signed [cb_route_pkg::CB_LANES*RSA_DW-1:0] i_douta,
  cb_rd_if.map                                            i_slot,
  output logic signed [cb_route_pkg::CB_X*RSA_DW-1:0]     o_tb_dina,
  output logic signed [cb_route_pkg::CB_X*RSA_DW-1:0]     o_a_douta,
  output logic signed [cb_route_pkg::CB_Y*RSA_DW-1:0]     o_b_douta,
  output logic signed [cb_route_pkg::CB_X*RSA_DW-1:0]     o_m_douta,
  output logic                                            o_valid
);

  localparam int ROW_W = cb_route_pkg::CB_LANES * RSA_DW;

  logic [ROW_W-1:0] op_row;
  logic [ROW_W-1:0] tb_row;
  logic             sel_tb;
  logic             sel_a;
  logic             sel_b;
  logic             sel_m;

  function automatic logic [RSA_DW-1:0] lane(input logic [ROW_W-1:0] row,
                                             input int unsigned idx);
    return row[idx*RSA_DW +: RSA_DW];
  endfunction

  // ################################################
  // Lane reorder
  // ################################################

  // Mapping shared by the A, B and M operand ports
  function automatic logic [ROW_W-1:0] map_operand(input cb_route_pkg::cb_dir_e dir,
                                                   input logic l_k_0,
                                                   input logic [ROW_W-1:0] row);
    logic [ROW_W-1:0] res;
    res = '0;
    case (dir)
      cb_route_pkg::DIR_POS: res = row;
      cb_route_pkg::DIR_NEG: begin
        for (int i = 0; i < cb_route_pkg::CB_LANES; i++) begin
          res[i*RSA_DW +: RSA_DW] = lane(row, cb_route_pkg::CB_LANES - 1 - i);
        end
      end
      cb_route_pkg::DIR_NEW: begin
        // New landmark pair lands in lanes 0 and 1, upper lanes stay zero
        res[0 +: RSA_DW]      = lane(row, cb_route_pkg::new_pair_lane(l_k_0, 1'b0));
        res[RSA_DW +: RSA_DW] = lane(row, cb_route_pkg::new_pair_lane(l_k_0, 1'b1));
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  // Transfer table walks the pair across the lanes, one placement per step
  function automatic logic [ROW_W-1:0] map_transfer(
      input cb_route_pkg::cb_dir_e dir,
      input logic l_k_0,
      input logic [cb_seq_pkg::SEQ_CNT_DW-1:0] step,
      input logic [ROW_W-1:0] row);
    logic [RSA_DW-1:0] hi;
    logic [RSA_DW-1:0] lo;
    logic [ROW_W-1:0]  res;
    hi  = lane(row, cb_route_pkg::new_pair_lane(l_k_0, 1'b1));
    lo  = lane(row, cb_route_pkg::new_pair_lane(l_k_0, 1'b0));
    res = '0;
    if (dir == cb_route_pkg::DIR_NEW) begin
      case (step)
        'd0: res[3*RSA_DW +: RSA_DW] = hi;
        'd1: res[0 +: RSA_DW] = lo;
        'd2: res[0 +: 2*RSA_DW] = {lo, hi};
        'd3: res[RSA_DW +: 2*RSA_DW] = {lo, hi};
        'd4: res[2*RSA_DW +: 2*RSA_DW] = {lo, hi};
        default: res = '0;
      endcase
    end
    return res;
  endfunction

  assign op_row = map_operand(i_slot.dir, i_slot.l_k_0, i_douta);
  assign tb_row = map_transfer(i_slot.dir, i_slot.l_k_0, i_slot.step, i_douta);

  // ################################################
  // Destination steering
  // ################################################

  assign sel_tb = i_slot.valid && (i_slot.dest == cb_route_pkg::DEST_TB);
  assign sel_a  = i_slot.valid && (i_slot.dest == cb_route_pkg::DEST_A);
  assign sel_b  = i_slot.valid && (i_slot.dest == cb_route_pkg::DEST_B);
  assign sel_m  = i_slot.valid && (i_slot.dest == cb_route_pkg::DEST_M);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_valid   <= 1'b0;
      o_tb_dina <= '0;
    end else begin
      o_valid   <= i_slot.valid;
      o_tb_dina <= sel_tb ? tb_row : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_a_douta <= '0;
    end else begin
      o_a_douta <= sel_a ? op_row : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_b_douta <= '0;
    end else begin
      o_b_douta <= sel_b ? op_row : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_m_douta <= '0;
    end else begin
      o_m_douta <= sel_m ? op_row : '0;
    end
  end

endmodule

/* src/cb_read_top.sv */
`timescale 1ns/1ps

module cb_read_top #(
  parameter int RSA_DW = 32,
  parameter int CB_AW  = 6
) (
  input  logic                                            clk,
  input  logic                                            sys_rst,
  input  logic                                            i_cmd_valid,
  input  logic [CB_AW-1:0]                                i_cmd_base,
  input  logic [cb_seq_pkg::SEQ_CNT_DW-1:0]               i_cmd_len,
  input  cb_route_pkg::cb_dest_e                          i_cmd_dest,
  input  cb_route_pkg::cb_dir_e                           i_cmd_dir,
  input  logic [1:0]                                      i_cmd_lm_idx,
  input  logic                                            i_wr_en,
  input  logic [CB_AW-1:0]                                i_wr_addr,
  input  logic [cb_route_pkg::CB_LANES*RSA_DW-1:0]        i_wr_data,
  output logic                                            o_cmd_ready,
  output logic                                            o_out_valid,
  output logic                                            o_done,
  output logic signed [cb_route_pkg::CB_X*RSA_DW-1:0]     o_tb_dina,
  output logic signed [cb_route_pkg::CB_X*RSA_DW-1:0]     o_a_douta,
  output logic signed [cb_route_pkg::CB_Y*RSA_DW-1:0]     o_b_douta,
  output logic signed [cb_route_pkg::CB_X*RSA_DW-1:0]     o_m_douta
);

  logic                                            cnt_load;
  logic                                            cnt_en;
  logic                                            cnt_last;
  logic [CB_AW-1:0]                                cnt_addr;
  logic [cb_seq_pkg::SEQ_CNT_DW-1:0]               cnt_step;
  logic signed [cb_route_pkg::CB_LANES*RSA_DW-1:0] bank_douta;

  // Issued read slot, and the same slot once it leaves the bank
  cb_rd_if #(.CB_AW(CB_AW)) rd_issue ();
  cb_rd_if #(.CB_AW(CB_AW)) rd_slot ();

  cb_seq_fsm #(.CB_AW(CB_AW)) u_seq_fsm (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_dest   (i_cmd_dest),
    .i_cmd_dir    (i_cmd_dir),
    .i_cmd_lm_idx (i_cmd_lm_idx),
    .i_cnt_addr   (cnt_addr),
    .i_cnt_step   (cnt_step),
    .i_cnt_last   (cnt_last),
    .o_cmd_ready  (o_cmd_ready),
    .o_cnt_load   (cnt_load),
    .o_cnt_en     (cnt_en),
    .o_done       (o_done),
    .o_rd         (rd_issue.issue)
  );

  cb_step_counter #(.CB_AW(CB_AW)) u_step_counter (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_load  (cnt_load),
    .i_en    (cnt_en),
    .i_base  (i_cmd_base),
    .i_len   (i_cmd_len),
    .o_addr  (cnt_addr),
    .o_step  (cnt_step),
    .o_last  (cnt_last)
  );

  cb_bank #(.RSA_DW(RSA_DW), .CB_AW(CB_AW)) u_bank (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .i_rd      (rd_issue.bank),
    .o_slot    (rd_slot.map),
    .o_douta   (bank_douta)
  );

  cb_douta_map #(.RSA_DW(RSA_DW)) u_douta_map (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_douta   (bank_douta),
    .i_slot    (rd_slot.map),
    .o_tb_dina (o_tb_dina),
    .o_a_douta (o_a_douta),
    .o_b_douta (o_b_douta),
    .o_m_douta (o_m_douta),
    .o_valid   (o_out_valid)
  );

endmodule

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD = 20
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

endmodule

/* bench/cb_read_assertions.sv */
`timescale 1ns/1ps

module cb_read_assertions #(
  parameter int RSA_DW = 32
) (
  input logic                                     clk,
  input logic                                     sys_rst,
  input logic                                     i_cmd_ready,
  input logic                                     i_out_valid,
  input logic                                     i_done,
  input logic [cb_route_pkg::CB_LANES*RSA_DW-1:0] i_tb_dina,
  input logic [cb_route_pkg::CB_LANES*RSA_DW-1:0] i_a_douta,
  input logic [cb_route_pkg::CB_LANES*RSA_DW-1:0] i_b_douta,
  input logic [cb_route_pkg::CB_LANES*RSA_DW-1:0] i_m_douta
);

  // Only the selected destination carries data
  a_one_port: assert property (@(posedge clk) disable iff (sys_rst)
    $onehot0({|i_tb_dina, |i_a_douta, |i_b_douta, |i_m_douta}))
    else $error("More than one data port is nonzero");

  a_zero_idle: assert property (@(posedge clk) disable iff (sys_rst)
    !i_out_valid |-> (i_tb_dina == '0 && i_a_douta == '0 && i_b_douta == '0 && i_m_douta == '0))
    else $error("Data port nonzero without a valid beat");

  // No new command is taken while a burst is on the outputs
  a_ready_low: assert property (@(posedge clk) disable iff (sys_rst)
    i_out_valid |-> !i_cmd_ready)
    else $error("Command ready during an output beat");

  a_done_valid: assert property (@(posedge clk) disable iff (sys_rst)
    i_done |-> i_out_valid)
    else $error("Done pulse without a valid beat");

endmodule

bind cb_read_top cb_read_assertions #(.RSA_DW(RSA_DW)) u_assertions (
  .clk         (clk),
  .sys_rst     (sys_rst),
  .i_cmd_ready (o_cmd_ready),
  .i_out_valid (o_out_valid),
  .i_done      (o_done),
  .i_tb_dina   (o_tb_dina),
  .i_a_douta   (o_a_douta),
  .i_b_douta   (o_b_douta),
  .i_m_douta   (o_m_douta)
);

/* bench/cb_read_tb.sv */
`timescale 1ns/1ps

module cb_read_tb;

  localparam int RSA_DW     = 32;
  localparam int CB_AW      = 6;
  localparam int DEPTH      = 2 ** CB_AW;
  localparam int LANES      = cb_route_pkg::CB_LANES;
  localparam int CLK_PERIOD = 20;
  // Beats per test: 24 + 18 + 14 + 13 + 10 + 6
  localparam int TOTAL_BEATS = 85;

  typedef logic signed [LANES*RSA_DW-1:0] row_t;

  logic                              clk;
  logic                              sys_rst;
  logic                              i_cmd_valid;
  logic [CB_AW-1:0]                  i_cmd_base;
  logic [cb_seq_pkg::SEQ_CNT_DW-1:0] i_cmd_len;
  cb_route_pkg::cb_dest_e            i_cmd_dest;
  cb_route_pkg::cb_dir_e             i_cmd_dir;
  logic [1:0]                        i_cmd_lm_idx;
  logic                              i_wr_en;
  logic [CB_AW-1:0]                  i_wr_addr;
  logic [LANES*RSA_DW-1:0]           i_wr_data;
  logic                              o_cmd_ready;
  logic                              o_out_valid;
  logic                              o_done;
  row_t                              o_tb_dina;
  row_t                              o_a_douta;
  row_t                              o_b_douta;
  row_t                              o_m_douta;

  // Copy of every row written into the buffer
  row_t shadow [DEPTH];

  tb_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk_gen (.o_clk(clk));

  cb_read_top #(.RSA_DW(RSA_DW), .CB_AW(CB_AW)) DUT (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_base   (i_cmd_base),
    .i_cmd_len    (i_cmd_len),
    .i_cmd_dest   (i_cmd_dest),
    .i_cmd_dir    (i_cmd_dir),
    .i_cmd_lm_idx (i_cmd_lm_idx),
    .i_wr_en      (i_wr_en),
    .i_wr_addr    (i_wr_addr),
    .i_wr_data    (i_wr_data),
    .o_cmd_ready  (o_cmd_ready),
    .o_out_valid  (o_out_valid),
    .o_done       (o_done),
    .o_tb_dina    (o_tb_dina),
    .o_a_douta    (o_a_douta),
    .o_b_douta    (o_b_douta),
    .o_m_douta    (o_m_douta)
  );

  // ################################################
  // Failure reporting and compares
  // ################################################

  task automatic fail_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic compare_row(input string name, input row_t exp, input row_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
      fail_run();
    end
  endtask

  // ################################################
  // Reference model
  // ################################################

  // Expected contents of one output port for one beat
  function automatic row_t model_port(input cb_route_pkg::cb_dest_e port,
                                      input cb_route_pkg::cb_dest_e dest,
                                      input cb_route_pkg::cb_dir_e dir,
                                      input logic lk0, input int step, input row_t row);
    logic [RSA_DW-1:0] lane_in [LANES];
    logic [RSA_DW-1:0] lane_out [LANES];
    int                lo_pos [5];
    int                hi_pos [5];
    int                lo;
    row_t              res;
    // Transfer placement of the pair per step, -1 where that word is not placed
    lo_pos = '{-1, 0, 1, 2, 3};
    hi_pos = '{3, -1, 0, 1, 2};
    lo     = lk0 ? 0 : 2;
    for (int i = 0; i < LANES; i++) begin
      lane_in[i]  = row[i*RSA_DW +: RSA_DW];
      lane_out[i] = '0;
    end
    if (port == dest && dir == cb_route_pkg::DIR_NEW) begin
      if (port != cb_route_pkg::DEST_TB) begin
        lane_out[0] = lane_in[lo];
        lane_out[1] = lane_in[lo + 1];
      end else if (step < 5) begin
        if (lo_pos[step] >= 0) lane_out[lo_pos[step]] = lane_in[lo];
        if (hi_pos[step] >= 0) lane_out[hi_pos[step]] = lane_in[lo + 1];
      end
    end else if (port == dest && port != cb_route_pkg::DEST_TB) begin
      for (int i = 0; i < LANES; i++) begin
        if (dir == cb_route_pkg::DIR_POS) lane_out[i] = lane_in[i];
        if (dir == cb_route_pkg::DIR_NEG) lane_out[i] = lane_in[LANES - 1 - i];
      end
    end
    for (int i = 0; i < LANES; i++) begin
      res[i*RSA_DW +: RSA_DW] = lane_out[i];
    end
    return res;
  endfunction

  // ################################################
  // Drivers
  // ################################################

  // Inputs change and outputs are sampled 2 ns after each rising edge
  task automatic wait_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic write_row(input logic [CB_AW-1:0] addr, input row_t data);
    i_wr_en      = 1'b1;
    i_wr_addr    = addr;
    i_wr_data    = data;
    shadow[addr] = data;
    wait_cycle();
    i_wr_en = 1'b0;
  endtask

  function automatic row_t random_row();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic check_beat(input cb_route_pkg::cb_dest_e dest, input cb_route_pkg::cb_dir_e dir,
                            input logic lk0, input int step, input row_t row);
    compare_row("o_tb_dina", model_port(cb_route_pkg::DEST_TB, dest, dir, lk0, step, row),
                o_tb_dina);
    compare_row("o_a_douta", model_port(cb_route_pkg::DEST_A, dest, dir, lk0, step, row),
                o_a_douta);
    compare_row("o_b_douta", model_port(cb_route_pkg::DEST_B, dest, dir, lk0, step, row),
                o_b_douta);
    compare_row("o_m_douta", model_port(cb_route_pkg::DEST_M, dest, dir, lk0, step, row),
                o_m_douta);
  endtask

  // Issues one command and checks every beat, o_done and the handshake timing
  task automatic run_read(input logic [CB_AW-1:0] base,
                          input logic [cb_seq_pkg::SEQ_CNT_DW-1:0] len,
                          input cb_route_pkg::cb_dest_e dest, input cb_route_pkg::cb_dir_e dir,
                          input logic [1:0] lm_idx);
    int               n_exp;
    int               beats;
    int               cyc;
    bit               burst_over;
    logic [CB_AW-1:0] addr;
    n_exp      = (len == '0) ? 1 : int'(len);
    beats      = 0;
    cyc        = 0;
    burst_over = 1'b0;
    while (o_cmd_ready !== 1'b1) wait_cycle();
    i_cmd_valid  = 1'b1;
    i_cmd_base   = base;
    i_cmd_len    = len;
    i_cmd_dest   = dest;
    i_cmd_dir    = dir;
    i_cmd_lm_idx = lm_idx;
    wait_cycle();
    i_cmd_valid = 1'b0;
    while (!burst_over) begin
      if (o_out_valid === 1'b1) begin
        compare_flag("o_cmd_ready", 1'b0, o_cmd_ready);
        if (beats == 0) compare_count("first beat latency", 3, cyc);
        addr = base + CB_AW'(beats);
        check_beat(dest, dir, lm_idx[0], beats, shadow[addr]);
        compare_flag("o_done", beats == n_exp - 1, o_done);
        beats++;
      end else if (beats > 0) begin
        // First idle cycle behind the burst
        burst_over = 1'b1;
      end else begin
        compare_flag("o_cmd_ready", 1'b0, o_cmd_ready);
        compare_flag("o_done", 1'b0, o_done);
      end
      if (!burst_over) begin
        wait_cycle();
        cyc++;
      end
    end
    compare_count("beat count", n_exp, beats);
    compare_flag("o_cmd_ready", 1'b1, o_cmd_ready);
    compare_flag("o_done", 1'b0, o_done);
  endtask

  // ################################################
  // Directed tests
  // ################################################

  task automatic pos_neg_reads();
    run_read(6'd4, 10'd4, cb_route_pkg::DEST_A, cb_route_pkg::DIR_POS, 2'd0);
    run_read(6'd9, 10'd4, cb_route_pkg::DEST_B, cb_route_pkg::DIR_POS, 2'd0);
    run_read(6'd14, 10'd4, cb_route_pkg::DEST_M, cb_route_pkg::DIR_POS, 2'd0);
    run_read(6'd4, 10'd4, cb_route_pkg::DEST_A, cb_route_pkg::DIR_NEG, 2'd0);
    run_read(6'd21, 10'd4, cb_route_pkg::DEST_B, cb_route_pkg::DIR_NEG, 2'd0);
    run_read(6'd30, 10'd4, cb_route_pkg::DEST_M, cb_route_pkg::DIR_NEG, 2'd0);
  endtask

  task automatic new_operand_pairs();
    // Landmark bit 1 must not change the pair
    run_read(6'd33, 10'd3, cb_route_pkg::DEST_A, cb_route_pkg::DIR_NEW, 2'd1);
    run_read(6'd36, 10'd3, cb_route_pkg::DEST_B, cb_route_pkg::DIR_NEW, 2'd3);
    run_read(6'd39, 10'd3, cb_route_pkg::DEST_M, cb_route_pkg::DIR_NEW, 2'd1);
    run_read(6'd33, 10'd3, cb_route_pkg::DEST_A, cb_route_pkg::DIR_NEW, 2'd2);
    run_read(6'd42, 10'd3, cb_route_pkg::DEST_B, cb_route_pkg::DIR_NEW, 2'd0);
    run_read(6'd45, 10'd3, cb_route_pkg::DEST_M, cb_route_pkg::DIR_NEW, 2'd2);
  endtask

  task automatic new_transfer_steps();
    run_read(6'd20, 10'd7, cb_route_pkg::DEST_TB, cb_route_pkg::DIR_NEW, 2'd3);
    run_read(6'd40, 10'd7, cb_route_pkg::DEST_TB, cb_route_pkg::DIR_NEW, 2'd0);
  endtask

  task automatic zero_routes();
    run_read(6'd50, 10'd3, cb_route_pkg::DEST_TB, cb_route_pkg::DIR_POS, 2'd1);
    run_read(6'd52, 10'd2, cb_route_pkg::DEST_TB, cb_route_pkg::DIR_NEG, 2'd0);
    run_read(6'd1, 10'd2, cb_route_pkg::DEST_A, cb_route_pkg::DIR_IDLE, 2'd0);
    run_read(6'd3, 10'd2, cb_route_pkg::DEST_B, cb_route_pkg::DIR_IDLE, 2'd1);
    run_read(6'd5, 10'd2, cb_route_pkg::DEST_M, cb_route_pkg::DIR_IDLE, 2'd0);
    run_read(6'd7, 10'd2, cb_route_pkg::DEST_TB, cb_route_pkg::DIR_IDLE, 2'd1);
  endtask

  // Back to back commands, a zero length reads a single row
  task automatic back_to_back_cmds();
    run_read(6'd10, 10'd0, cb_route_pkg::DEST_A, cb_route_pkg::DIR_POS, 2'd0);
    run_read(6'd11, 10'd1, cb_route_pkg::DEST_B, cb_route_pkg::DIR_NEG, 2'd0);
    run_read(6'd12, 10'd2, cb_route_pkg::DEST_M, cb_route_pkg::DIR_POS, 2'd0);
    run_read(6'd13, 10'd5, cb_route_pkg::DEST_TB, cb_route_pkg::DIR_NEW, 2'd1);
    run_read(6'd18, 10'd1, cb_route_pkg::DEST_A, cb_route_pkg::DIR_NEW, 2'd0);
  endtask

  task automatic wrap_burst();
    write_row(6'd62, random_row());
    write_row(6'd63, random_row());
    write_row(6'd0, random_row());
    write_row(6'd1, random_row());
    run_read(6'd61, 10'd6, cb_route_pkg::DEST_B, cb_route_pkg::DIR_POS, 2'd0);
  endtask

  // ################################################
  // Main sequence and watchdog
  // ################################################

  initial begin
    #(TOTAL_BEATS * 40 * CLK_PERIOD + 2000);
    $display("Timeout: the run hung and the tests did not finish in time");
    fail_run();
  end

  initial begin
    void'($urandom(32'he4ce));
    sys_rst      = 1'b1;
    i_cmd_valid  = 1'b0;
    i_cmd_base   = '0;
    i_cmd_len    = '0;
    i_cmd_dest   = cb_route_pkg::DEST_TB;
    i_cmd_dir    = cb_route_pkg::DIR_IDLE;
    i_cmd_lm_idx = '0;
    i_wr_en      = 1'b0;
    i_wr_addr    = '0;
    i_wr_data    = '0;
    repeat (10) wait_cycle();
    sys_rst = 1'b0;
    wait_cycle();
    compare_flag("o_cmd_ready", 1'b1, o_cmd_ready);
    compare_flag("o_out_valid", 1'b0, o_out_valid);
    compare_flag("o_done", 1'b0, o_done);
    check_beat(cb_route_pkg::DEST_A, cb_route_pkg::DIR_IDLE, 1'b0, 0, '0);
    for (int a = 0; a < DEPTH; a++) begin
      write_row(CB_AW'(a), random_row());
    end
    pos_neg_reads();
    new_operand_pairs();
    new_transfer_steps();
    zero_routes();
    back_to_back_cmds();
    wrap_burst();
    $display("Verification passed");
    $finish;
  end

endmodule

/* sources.f */
common/cb_route_pkg.sv
common/cb_seq_pkg.sv
common/cb_rd_if.sv
src/cb_step_counter.sv
src/cb_seq_fsm.sv
cb_bank/cb_bank.sv
cb_map/cb_douta_map.sv
src/cb_read_top.sv
bench/tb_clk_gen.sv
bench/cb_read_assertions.sv
bench/cb_read_tb.sv

/* Bender.yml */
package:
  name: cb_read

sources:
  - common/cb_route_pkg.sv
  - common/cb_seq_pkg.sv
  - common/cb_rd_if.sv
  - src/cb_step_counter.sv
  - src/cb_seq_fsm.sv
  - cb_bank/cb_bank.sv
  - cb_map/cb_douta_map.sv
  - src/cb_read_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/cb_read_assertions.sv
      - bench/cb_read_tb.sv
